// ==== design/bridge_settings.svh ====
// region size must be a power of two; regions sit back to back from the base address
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// number of apb slaves behind the bridge
// one psel bit and one prdata word each
`define BRIDGE_NUM_SLAVES 4

// first byte of region 0
`define BRIDGE_BASE_ADDR 32'h0000_0000

// bytes per slave region
// power of two, so the decode is a shift
`define BRIDGE_REGION_BYTES 256

// access cycles without pready before the bridge gives up
// an expired access answers slverr with zero read data
`define BRIDGE_TIMEOUT 8

// memory map for the defaults above
//   slave 0  0x000 - 0x0ff
//   slave 1  0x100 - 0x1ff
//   slave 2  0x200 - 0x2ff
//   slave 3  0x300 - 0x3ff
//   0x400 and up  decerr, no apb cycle

`endif

// ==== design/bridge_pkg.sv ====
// shared types only; widths fixed at 32-bit address and data, slave count from the settings
`default_nettype none

`include "bridge_settings.svh"

package bridge_pkg;

  // byte address, full 32 bits seen on paddr
  typedef logic [31:0] addr_t;

  // one bus word, axi and apb side alike
  typedef logic [31:0] data_t;

  // byte lanes of data_t
  typedef logic [3:0] strb_t;

  // one-hot psel, all zero when idle or unmapped
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] sel_t;

  // axi4-lite bresp / rresp codes
  // exokay never produced, no exclusive access here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,  // pslverr or timeout
    DECERR = 2'b11   // address outside every region
  } axi_resp_e;

  // apb transfer phase
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // psel low
    SETUP  = 2'b01,  // psel high, penable low
    ACCESS = 2'b10   // psel and penable high until pready or timeout
  } apb_phase_e;

endpackage

`default_nettype wire

// ==== design/apb_req_if.sv ====
// one transfer in flight at a time; valid is a single-cycle strobe with no ready back
`timescale 1ns/1ps
`default_nettype none

interface apb_req_if;
  import bridge_pkg::*;

  logic  valid;    // one cycle per accepted axi request
  addr_t addr;     // captured araddr or awaddr
  data_t wdata;    // write payload, don't care on reads
  strb_t strb;     // byte enables, zero on reads
  logic  write;    // 1 write, 0 read
  sel_t  sel;      // decoded one-hot slave
  logic  dec_err;  // no region covers addr

  // axi input side
  modport src (
    output valid, addr, wdata, strb, write, sel, dec_err
  );

  // apb sequencer
  modport dst (
    input valid, addr, wdata, strb, write, sel, dec_err
  );

endinterface

`default_nettype wire

// ==== design/apb_rsp_if.sv ====
// carries one result per request; valid is a single-cycle strobe with no ready back
`timescale 1ns/1ps
`default_nettype none

interface apb_rsp_if;
  import bridge_pkg::*;

  logic      valid;  // transfer finished, one cycle
  logic      write;  // selects b or r channel
  data_t     rdata;  // zero on timeout and decerr
  axi_resp_e resp;   // okay, slverr or decerr

  // apb sequencer
  modport src (
    output valid, write, rdata, resp
  );

  // axi response side
  modport dst (
    input valid, write, rdata, resp
  );

endinterface

`default_nettype wire

// ==== design/axi_lite_slave_port.sv ====
// write needs aw and w in the same cycle; read wins a tie; one request open until rsp_done
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module axi_lite_slave_port (
  input  logic              s_axi_clk,
  input  logic              reset,
  input  bridge_pkg::addr_t awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  bridge_pkg::data_t wdata,
  input  bridge_pkg::strb_t wstrb,
  input  logic              wvalid,
  output logic              wready,
  input  bridge_pkg::addr_t araddr,
  input  logic              arvalid,
  output logic              arready,
  input  logic              rsp_done,  // master took b or r
  apb_req_if.src            req
);
  import bridge_pkg::*;

  localparam int unsigned REGION_SHIFT = $clog2(`BRIDGE_REGION_BYTES);

  logic        busy;        // request outstanding
  logic        ar_go;       // read handshake this cycle
  logic        aw_go;       // write handshake, aw and w together
  logic        req_valid;
  addr_t       cap_addr;
  data_t       cap_wdata;
  strb_t       cap_strb;
  logic        cap_write;
  logic [32:0] addr_diff;   // bit 32 is the borrow, address below base
  logic [31-REGION_SHIFT:0] region_idx;

  // read first, write only when both halves are offered
  assign ar_go = !busy && arvalid;
  assign aw_go = !busy && !arvalid && awvalid && wvalid;

  assign arready = ar_go;
  assign awready = aw_go;
  assign wready  = aw_go;

  always_ff @(posedge s_axi_clk) begin
    if (reset) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      req_valid <= ar_go || aw_go;  // strobe the cycle after acceptance
      if (ar_go || aw_go) busy <= 1'b1;
      else if (rsp_done)  busy <= 1'b0;  // rearm
    end
  end

  // payload, no reset needed
  always_ff @(posedge s_axi_clk) begin
    if (ar_go || aw_go) begin
      cap_addr  <= ar_go ? araddr : awaddr;
      cap_wdata <= wdata;
      cap_strb  <= ar_go ? '0 : wstrb;  // apb wants pstrb low on reads
      cap_write <= aw_go;
    end
  end

  // equal regions from the base; slave index is offset over region size
  assign addr_diff  = {1'b0, cap_addr} - {1'b0, `BRIDGE_BASE_ADDR};
  assign region_idx = addr_diff[31:REGION_SHIFT];

  assign req.valid   = req_valid;
  assign req.addr    = cap_addr;
  assign req.wdata   = cap_wdata;
  assign req.strb    = cap_strb;
  assign req.write   = cap_write;
  assign req.dec_err = addr_diff[32] || (region_idx >= `BRIDGE_NUM_SLAVES);
  assign req.sel     = req.dec_err ? '0 : sel_t'(1) << region_idx;

  // a b or r handshake only closes a request that was taken
  a_done_busy : assert property (@(posedge s_axi_clk) disable iff (reset)
    rsp_done |-> busy)
    else $error("rsp_done with no request outstanding");

endmodule

`default_nettype wire

// ==== design/apb_transfer_fsm.sv ====
// apb4 master for one transfer at a time; only the selected slave's pready/pslverr/prdata count
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module apb_transfer_fsm (
  input  logic              s_axi_clk,
  input  logic              reset,
  apb_req_if.dst            req,
  apb_rsp_if.src            rsp,
  output bridge_pkg::addr_t paddr,
  output bridge_pkg::sel_t  psel,
  output logic              penable,
  output logic              pwrite,
  output bridge_pkg::data_t pwdata,
  output bridge_pkg::strb_t pstrb,
  input  bridge_pkg::sel_t  pready,
  input  logic [`BRIDGE_NUM_SLAVES*$bits(bridge_pkg::data_t)-1:0] prdata,
  input  bridge_pkg::sel_t  pslverr
);
  import bridge_pkg::*;

  localparam int DW    = $bits(data_t);
  localparam int CNT_W = $clog2(`BRIDGE_TIMEOUT + 1);

  apb_phase_e       phase;
  logic [CNT_W-1:0] wait_cnt;    // access cycles left before timeout
  sel_t             sel_q;
  logic             ready_sel;   // pready of the addressed slave
  logic             err_sel;
  data_t            rdata_sel;
  logic             timeout;
  logic             done;        // access ends this cycle
  logic             dec_hit;     // unmapped request, answer right away
  logic             rsp_valid_q;
  logic             rsp_write_q;
  data_t            rsp_rdata_q;
  axi_resp_e        rsp_resp_q;

  assign ready_sel = |(pready & sel_q);
  assign err_sel   = |(pslverr & sel_q);

  // mux prdata by the one-hot select
  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      if (sel_q[i]) rdata_sel = rdata_sel | prdata[i*DW +: DW];
    end
  end

  assign timeout = (phase == ACCESS) && !ready_sel && (wait_cnt == CNT_W'(1));
  assign done    = (phase == ACCESS) && (ready_sel || timeout);
  assign dec_hit = req.valid && req.dec_err;

  always_ff @(posedge s_axi_clk) begin
    if (reset) begin
      phase       <= IDLE;
      wait_cnt    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= done;
      case (phase)
        IDLE:   if (req.valid && !req.dec_err) phase <= SETUP;
        SETUP: begin
          phase    <= ACCESS;
          wait_cnt <= CNT_W'(`BRIDGE_TIMEOUT);  // reload per transfer
        end
        ACCESS: begin
          if (done) phase <= IDLE;              // psel drops next cycle
          else      wait_cnt <= wait_cnt - 1'b1;
        end
        default: phase <= IDLE;
      endcase
    end
  end

  // apb payload and result, held from capture
  always_ff @(posedge s_axi_clk) begin
    if (phase == IDLE && req.valid) begin
      paddr  <= req.addr;
      pwdata <= req.wdata;
      pstrb  <= req.strb;
      pwrite <= req.write;
      sel_q  <= req.sel;
    end
    if (done) begin
      rsp_write_q <= pwrite;
      rsp_rdata_q <= timeout ? '0 : rdata_sel;
      rsp_resp_q  <= (timeout || err_sel) ? SLVERR : OKAY;
    end
  end

  assign psel    = (phase != IDLE) ? sel_q : '0;
  assign penable = (phase == ACCESS);

  // decerr bypasses the apb phases
  assign rsp.valid = rsp_valid_q || dec_hit;
  assign rsp.write = dec_hit ? req.write : rsp_write_q;
  assign rsp.rdata = dec_hit ? '0 : rsp_rdata_q;
  assign rsp.resp  = dec_hit ? DECERR : rsp_resp_q;

  a_psel_onehot : assert property (@(posedge s_axi_clk) disable iff (reset)
    $onehot0(psel))
    else $error("psel not one-hot");

  // access always follows a setup cycle to the same slave
  a_penable_access : assert property (@(posedge s_axi_clk) disable iff (reset)
    penable |-> (psel != '0) && $past(psel) == psel)
    else $error("penable without matching setup");

endmodule

`default_nettype wire

// ==== design/axi_response_port.sv ====
// holds b or r until the master takes it; a new result never arrives while one is held
`timescale 1ns/1ps
`default_nettype none

module axi_response_port (
  input  logic                  s_axi_clk,
  input  logic                  reset,
  apb_rsp_if.dst                rsp,
  output bridge_pkg::axi_resp_e bresp,
  output logic                  bvalid,
  input  logic                  bready,
  output bridge_pkg::data_t     rdata,
  output bridge_pkg::axi_resp_e rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic                  rsp_done  // handshake, frees the input side
);
  import bridge_pkg::*;

  logic load_b;
  logic load_r;

  assign load_b = rsp.valid && rsp.write;
  assign load_r = rsp.valid && !rsp.write;

  always_ff @(posedge s_axi_clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (load_b)      bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;  // drop after the handshake
      if (load_r)      rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // channel payload
  always_ff @(posedge s_axi_clk) begin
    if (load_b) bresp <= rsp.resp;
    if (load_r) begin
      rdata <= rsp.rdata;
      rresp <= rsp.resp;
    end
  end

  assign rsp_done = (bvalid && bready) || (rvalid && rready);

  // axi rule, r payload frozen under back-pressure
  a_r_stable : assert property (@(posedge s_axi_clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("r channel changed while stalled");

endmodule

`default_nettype wire

// ==== design/axi_apb_bridge.sv ====
// axi4-lite to apb4 bridge, one outstanding transfer, no pprot; prdata is one flat bus
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module axi_apb_bridge (
  input  logic                  s_axi_clk,
  input  logic                  reset,
  // axi4-lite write address and data
  input  bridge_pkg::addr_t     s_axi_awaddr,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  input  bridge_pkg::data_t     s_axi_wdata,
  input  bridge_pkg::strb_t     s_axi_wstrb,
  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  // write response
  output bridge_pkg::axi_resp_e s_axi_bresp,
  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,
  // read address and data
  input  bridge_pkg::addr_t     s_axi_araddr,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  output bridge_pkg::data_t     s_axi_rdata,
  output bridge_pkg::axi_resp_e s_axi_rresp,
  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready,
  // apb master
  output bridge_pkg::addr_t     m_apb_paddr,
  output bridge_pkg::sel_t      m_apb_psel,
  output logic                  m_apb_penable,
  output logic                  m_apb_pwrite,
  output bridge_pkg::data_t     m_apb_pwdata,
  output bridge_pkg::strb_t     m_apb_pstrb,
  input  bridge_pkg::sel_t      m_apb_pready,
  input  logic [`BRIDGE_NUM_SLAVES*$bits(bridge_pkg::data_t)-1:0] m_apb_prdata,  // slave 0 low
  input  bridge_pkg::sel_t      m_apb_pslverr
);

  logic rsp_done;  // b/r handshake back to the input side

  apb_req_if req_link ();
  apb_rsp_if rsp_link ();

  axi_lite_slave_port u_slave_port (
    .s_axi_clk (s_axi_clk),
    .reset     (reset),
    .awaddr    (s_axi_awaddr),
    .awvalid   (s_axi_awvalid),
    .awready   (s_axi_awready),
    .wdata     (s_axi_wdata),
    .wstrb     (s_axi_wstrb),
    .wvalid    (s_axi_wvalid),
    .wready    (s_axi_wready),
    .araddr    (s_axi_araddr),
    .arvalid   (s_axi_arvalid),
    .arready   (s_axi_arready),
    .rsp_done  (rsp_done),
    .req       (req_link.src)
  );

  apb_transfer_fsm u_apb_fsm (
    .s_axi_clk (s_axi_clk),
    .reset     (reset),
    .req       (req_link.dst),
    .rsp       (rsp_link.src),
    .paddr     (m_apb_paddr),
    .psel      (m_apb_psel),
    .penable   (m_apb_penable),
    .pwrite    (m_apb_pwrite),
    .pwdata    (m_apb_pwdata),
    .pstrb     (m_apb_pstrb),
    .pready    (m_apb_pready),
    .prdata    (m_apb_prdata),
    .pslverr   (m_apb_pslverr)
  );

  axi_response_port u_rsp_port (
    .s_axi_clk (s_axi_clk),
    .reset     (reset),
    .rsp       (rsp_link.dst),
    .bresp     (s_axi_bresp),
    .bvalid    (s_axi_bvalid),
    .bready    (s_axi_bready),
    .rdata     (s_axi_rdata),
    .rresp     (s_axi_rresp),
    .rvalid    (s_axi_rvalid),
    .rready    (s_axi_rready),
    .rsp_done  (rsp_done)
  );

endmodule

`default_nettype wire

// ==== tb/bridge_checker.sv ====
// assumes one request open at a time and equal regions from the base; one line per transfer
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module bridge_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  bridge_pkg::addr_t     awaddr, araddr, paddr,
  input  bridge_pkg::data_t     wdata, rdata, pwdata,
  input  bridge_pkg::strb_t     wstrb, pstrb,
  input  logic                  awvalid, awready, wvalid, wready, bvalid, bready,
  input  logic                  arvalid, arready, rvalid, rready,
  input  bridge_pkg::axi_resp_e bresp, rresp,
  input  bridge_pkg::sel_t      psel, pready,
  input  logic                  penable, pwrite,
  input  logic                  finished,
  output int                    pass_cnt,
  output int                    fail_cnt
);
  import bridge_pkg::*;

  localparam int WORDS = `BRIDGE_NUM_SLAVES * `BRIDGE_REGION_BYTES / 4;

  data_t     mem [WORDS];  // expected slave contents
  logic      in_txn, t_write, t_dec, t_bad, t_ok, t_tmo;
  logic      seen, held, prev_psel, prev_en;
  addr_t     t_addr;
  data_t     t_wdata, snap_data;
  strb_t     t_strb;
  sel_t      t_sel;
  axi_resp_e snap_resp;
  int        acc_cnt, txn_no;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
    txn_no   = 0;
    for (int i = 0; i < WORDS; i++) mem[i] = 32'hc0de_0000 | (i * 4);
  end

  task automatic report_error(input string msg);
    $display("error: %s at %0t", msg, $time);
    if (in_txn) t_bad = 1'b1;
    else fail_cnt++;  // nothing open to charge it to
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s got %h exp %h at %0t", name, got, exp, $time);
    if (in_txn) t_bad = 1'b1;
    else fail_cnt++;
  endtask

  task automatic start_txn(input logic wr, input addr_t a, input data_t d, input strb_t s);
    logic [63:0] lo;
    in_txn  = 1'b1;
    t_write = wr;
    t_addr  = a;
    t_wdata = d;
    t_strb  = s;
    t_sel   = '0;
    for (int r = 0; r < `BRIDGE_NUM_SLAVES; r++) begin
      lo = 64'(`BRIDGE_BASE_ADDR) + 64'(r) * `BRIDGE_REGION_BYTES;  // region r start
      if (64'(a) >= lo && 64'(a) < lo + `BRIDGE_REGION_BYTES) t_sel[r] = 1'b1;
    end
    t_dec   = (t_sel == '0);  // no region holds it
    {t_bad, t_ok, t_tmo, seen, held} = '0;
    acc_cnt = 0;
  endtask

  // setup then access on the decoded slave, timeout after the access limit
  task automatic watch_apb();
    if (psel != '0) begin
      if (t_dec) report_error("psel raised for an unmapped address");
      else if (psel !== t_sel) report_mismatch("psel", 32'(psel), 32'(t_sel));
      if (paddr !== t_addr) report_mismatch("paddr", paddr, t_addr);
      if (pwrite !== t_write) report_mismatch("pwrite", 32'(pwrite), 32'(t_write));
      if (t_write && pwdata !== t_wdata) report_mismatch("pwdata", pwdata, t_wdata);
      if (pstrb !== t_strb) report_mismatch("pstrb", 32'(pstrb), 32'(t_strb));
      if (penable) begin
        if (!prev_psel) report_error("penable high without a setup cycle");
        acc_cnt++;
        if ((pready & psel) != '0) t_ok = 1'b1;
        else if (acc_cnt == `BRIDGE_TIMEOUT) t_tmo = 1'b1;
      end else if (prev_psel && !prev_en) report_error("setup cycle not followed by access");
    end else if (penable) report_error("penable high with psel low");
  endtask

  task automatic check_response(input axi_resp_e resp, input data_t data);
    axi_resp_e exp_resp;
    data_t     exp_data;
    int        idx;
    idx      = int'((t_addr - `BRIDGE_BASE_ADDR) / 4);
    exp_data = '0;  // decerr and timeout read back zero
    if (t_dec) exp_resp = DECERR;
    else if (t_tmo || t_addr[2]) exp_resp = SLVERR;
    else exp_resp = OKAY;
    if (!t_dec && !t_tmo && !t_ok) report_error("response before the apb access finished");
    if (!t_dec && !t_tmo) begin
      if (!t_write) exp_data = mem[idx];  // pslverr reads still carry the slave word
      else if (exp_resp == OKAY) begin
        for (int b = 0; b < 4; b++) if (t_strb[b]) mem[idx][8*b +: 8] = t_wdata[8*b +: 8];
      end
    end
    if (resp !== exp_resp) report_mismatch(t_write ? "bresp" : "rresp", 32'(resp), 32'(exp_resp));
    // error writes never land, so an error word keeps its fill value
    if (!t_write && data !== exp_data) report_mismatch("rdata", data, exp_data);
  endtask

  task automatic watch_response();
    logic      valid;
    logic      ready;
    axi_resp_e resp;
    valid = t_write ? bvalid : rvalid;
    ready = t_write ? bready : rready;
    resp  = t_write ? bresp : rresp;
    if (held && !valid) report_error("response valid dropped before the handshake");
    if (valid && !seen) begin
      if (psel != '0) report_error("response raised while psel still high");
      check_response(resp, rdata);
      seen      = 1'b1;
      snap_resp = resp;
      snap_data = rdata;
    end else if (valid) begin  // stalled, must hold
      if (resp !== snap_resp) report_mismatch("resp held", 32'(resp), 32'(snap_resp));
      if (!t_write && rdata !== snap_data) report_mismatch("rdata held", rdata, snap_data);
    end
    held = valid && !ready;
    if (valid && ready) begin
      txn_no++;
      if (t_bad) fail_cnt++;
      else pass_cnt++;
      $display("txn %0d %s addr %h resp %s %s", txn_no, t_write ? "write" : "read",
               t_addr, snap_resp.name(), t_bad ? "error" : "ok");
      in_txn = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      in_txn = 1'b0;
    end else if (!in_txn) begin
      if (psel != '0 || penable) report_error("apb bus active with no request open");
      if (arvalid && arready) start_txn(1'b0, araddr, '0, '0);  // read wins a tie
      else if (awvalid && awready && wvalid && wready) start_txn(1'b1, awaddr, wdata, wstrb);
    end else begin
      if (arready || awready || wready) report_error("request accepted while one is open");
      watch_apb();
      watch_response();
    end
    prev_psel = (psel != '0);
    prev_en   = penable;
  end

  always @(posedge finished) begin
    $display("checked %0d transfers, %0d passed, %0d failed", txn_no, pass_cnt, fail_cnt);
  end

endmodule

`default_nettype wire

// ==== tb/tb_axi_apb_bridge.sv ====
// one request in flight; slave model stalls pready 0..11 cycles; stimulus from a 16-bit lfsr
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module tb_axi_apb_bridge;
  import bridge_pkg::*;

  localparam int          NUM_TXN    = 300;
  localparam int          MAX_WAIT   = 11;  // longest pready delay, past the timeout
  localparam int          CLK_PERIOD = 10;
  localparam logic [15:0] SEED       = 16'd45045;
  localparam int          WORDS      = `BRIDGE_REGION_BYTES / 4;
  localparam int          RSH        = $clog2(`BRIDGE_REGION_BYTES);
  localparam int          DW         = $bits(data_t);

  logic      clk = 1'b0;
  logic      reset;
  addr_t     awaddr, araddr, paddr;
  data_t     wdata, rdata, pwdata;
  strb_t     wstrb, pstrb;
  logic      awvalid, awready, wvalid, wready, bvalid, bready;
  logic      arvalid, arready, rvalid, rready;
  axi_resp_e bresp, rresp;
  sel_t      psel;
  logic      penable, pwrite;
  sel_t      pready = '0;
  sel_t      pslverr = '0;
  logic [`BRIDGE_NUM_SLAVES*DW-1:0] prdata = '0;  // slave 0 in the low word
  logic      finished;
  int        pass_cnt, fail_cnt;
  logic [15:0] lfsr = SEED;
  data_t     smem [`BRIDGE_NUM_SLAVES][WORDS];    // apb slave storage
  int        ready_delay;                         // pready wait for the next access
  int        wait_left;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // apb slaves; sample at the edge, answer 1 ns later
  always @(posedge clk) begin
    sel_t  s_psel;
    logic  s_en;
    sel_t  s_rdy;
    addr_t s_addr;
    logic  s_wr;
    data_t s_wd;
    strb_t s_st;
    int    s;
    int    w;
    s_psel = psel;
    s_en   = penable;
    s_rdy  = pready;
    s_addr = paddr;
    s_wr   = pwrite;
    s_wd   = pwdata;
    s_st   = pstrb;
    s = 0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) if (s_psel[i]) s = i;
    w = int'(s_addr[RSH-1:2]);
    #1;
    if (reset || s_psel == '0) begin
      pready  = '0;
      pslverr = '0;
    end else begin
      if (!s_en) wait_left = ready_delay;  // setup cycle
      else if (s_rdy[s]) begin             // access completes here
        if (s_wr && !s_addr[2]) begin      // slverr writes are dropped
          for (int b = 0; b < 4; b++) if (s_st[b]) smem[s][w][8*b +: 8] = s_wd[8*b +: 8];
        end
      end else wait_left--;
      pready  = (s_en && s_rdy[s]) ? '0 : sel_t'(wait_left == 0) << s;
      pslverr = s_addr[2] ? s_psel : '0;  // bit 2 marks an error word
    end
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++)
      prdata[i*DW +: DW] = s_psel[i] ? smem[i][w] : (32'hbad0_0000 | i);  // junk off-select
  end

  // one axi transfer with random address, wait states and response stall
  task automatic run_txn();
    logic  is_wr;
    logic  probe_rd;
    addr_t addr;
    int    region;
    int    word;
    int    stall;
    is_wr  = rand_bits(1) != 0;
    region = int'(rand_bits(3));
    word   = int'(rand_bits(3)) * 2 + int'(rand_bits(2) == 0);  // bit 2 one time in four
    if (region == 7) addr = addr_t'(`BRIDGE_BASE_ADDR +
        `BRIDGE_NUM_SLAVES * `BRIDGE_REGION_BYTES + rand_bits(12) * 4);  // unmapped
    else addr = addr_t'(`BRIDGE_BASE_ADDR + (region % 4) * `BRIDGE_REGION_BYTES + word * 4);
    ready_delay = int'(rand_bits(4) % (MAX_WAIT + 1));
    stall       = int'(rand_bits(2));
    @(posedge clk);
    #1;
    if (is_wr) begin
      awaddr  = addr;
      wdata   = rand_bits(32);
      wstrb   = strb_t'(rand_bits(4));
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(posedge clk);
      while (!awready) @(posedge clk);
    end else begin
      araddr  = addr;
      arvalid = 1'b1;
      @(posedge clk);
      while (!arready) @(posedge clk);
    end
    #1;
    // second request offered while this one is open
    probe_rd = rand_bits(1) != 0;
    arvalid  = probe_rd;
    awvalid  = !probe_rd;
    wvalid   = !probe_rd;
    @(posedge clk);
    while (!(is_wr ? bvalid : rvalid)) @(posedge clk);
    repeat (stall) @(posedge clk);  // back-pressure
    #1;
    bready = is_wr;
    rready = !is_wr;
    @(posedge clk);
    #1;
    bready  = 1'b0;
    rready  = 1'b0;
    arvalid = 1'b0;  // probe ends with the handshake
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  axi_apb_bridge i_dut (
    .s_axi_clk     (clk),
    .reset         (reset),
    .s_axi_awaddr  (awaddr),
    .s_axi_awvalid (awvalid),
    .s_axi_awready (awready),
    .s_axi_wdata   (wdata),
    .s_axi_wstrb   (wstrb),
    .s_axi_wvalid  (wvalid),
    .s_axi_wready  (wready),
    .s_axi_bresp   (bresp),
    .s_axi_bvalid  (bvalid),
    .s_axi_bready  (bready),
    .s_axi_araddr  (araddr),
    .s_axi_arvalid (arvalid),
    .s_axi_arready (arready),
    .s_axi_rdata   (rdata),
    .s_axi_rresp   (rresp),
    .s_axi_rvalid  (rvalid),
    .s_axi_rready  (rready),
    .m_apb_paddr   (paddr),
    .m_apb_psel    (psel),
    .m_apb_penable (penable),
    .m_apb_pwrite  (pwrite),
    .m_apb_pwdata  (pwdata),
    .m_apb_pstrb   (pstrb),
    .m_apb_pready  (pready),
    .m_apb_prdata  (prdata),
    .m_apb_pslverr (pslverr)
  );

  bridge_checker u_check (.*);

  initial begin
    reset    = 1'b1;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    finished = 1'b0;
    ready_delay = 0;
    wait_left   = 0;
    for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++)
      for (int w = 0; w < WORDS; w++)
        smem[s][w] = 32'hc0de_0000 | (s * `BRIDGE_REGION_BYTES + w * 4);
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    for (int n = 0; n < NUM_TXN; n++) run_txn();
    repeat (2) @(posedge clk);
    finished = 1'b1;  // checker prints its totals
    #1;
    if (fail_cnt == 0 && pass_cnt == NUM_TXN) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog, 40 cycles per transfer is several times the worst case
  initial begin
    #((NUM_TXN * 40 + 10) * CLK_PERIOD);
    $display("watchdog expired before all transfers completed");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/bridge_pkg.sv
design/apb_req_if.sv
design/apb_rsp_if.sv
design/axi_lite_slave_port.sv
design/apb_transfer_fsm.sv
design/axi_response_port.sv
design/axi_apb_bridge.sv
tb/bridge_checker.sv
tb/tb_axi_apb_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the bridge testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_axi_apb_bridge -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && exit 0 || exit 1
